// ==== hdl/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define WORD_SIZE 16
`define NUM_REGS  4

// instruction fields
//   opcode [15:12]  rs [11:10]  rt [9:8]  rd [7:6]  func [5:0]
//   immediate [7:0]  jump target [11:0]

`define OPC_BNE   4'd0
`define OPC_BEQ   4'd1
`define OPC_ADI   4'd4
`define OPC_ORI   4'd5
`define OPC_LHI   4'd6
`define OPC_LWD   4'd7
`define OPC_SWD   4'd8
`define OPC_JMP   4'd9
`define OPC_RTYPE 4'd15

// func field under OPC_RTYPE
`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_WWD 6'd28
`define FN_HLT 6'd29

`endif

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;          // data, address and instruction
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;
    typedef logic [3:0] opcode_t;
    typedef logic [5:0] func_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LHI  // low byte of b into high byte
    } alu_op_t;

endpackage

`default_nettype wire

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module control_unit (
    input  cpu_pkg::word_t    instr,
    output cpu_pkg::reg_idx_t rs,
    output cpu_pkg::reg_idx_t rt,
    output cpu_pkg::reg_idx_t dest,
    output logic              reg_write,
    output logic              alu_src_imm,
    output logic              imm_signed,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              mem_read,
    output logic              mem_write,
    output logic              is_branch,
    output logic              branch_on_eq,
    output logic              is_jump,
    output logic              is_wwd,
    output logic              is_halt,
    output logic              uses_rs,
    output logic              uses_rt
);
    cpu_pkg::opcode_t opcode;
    cpu_pkg::func_t   func;

    assign opcode = instr[15:12];
    assign func   = instr[5:0];
    assign rs     = instr[11:10];
    assign rt     = instr[9:8];

    always_comb begin
        dest         = instr[9:8];  // i-type writes rt
        reg_write    = 1'b0;
        alu_src_imm  = 1'b1;
        imm_signed   = 1'b1;
        alu_op       = cpu_pkg::ALU_ADD;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        is_branch    = 1'b0;
        branch_on_eq = 1'b0;
        is_jump      = 1'b0;
        is_wwd       = 1'b0;
        is_halt      = 1'b0;
        uses_rs      = 1'b0;
        uses_rt      = 1'b0;

        case (opcode)
            `OPC_RTYPE: begin
                dest        = instr[7:6];
                alu_src_imm = 1'b0;
                case (func)
                    `FN_ADD, `FN_SUB, `FN_AND, `FN_ORR: begin
                        reg_write = 1'b1;
                        uses_rs   = 1'b1;
                        uses_rt   = 1'b1;
                        if (func == `FN_SUB)
                            alu_op = cpu_pkg::ALU_SUB;
                        else if (func == `FN_AND)
                            alu_op = cpu_pkg::ALU_AND;
                        else if (func == `FN_ORR)
                            alu_op = cpu_pkg::ALU_OR;
                    end
                    `FN_WWD: begin
                        is_wwd  = 1'b1;
                        uses_rs = 1'b1;
                    end
                    `FN_HLT: is_halt = 1'b1;
                    default: ;  // unsupported func, no-op
                endcase
            end
            `OPC_ADI: begin
                reg_write = 1'b1;
                uses_rs   = 1'b1;
            end
            `OPC_ORI: begin
                reg_write  = 1'b1;
                uses_rs    = 1'b1;
                imm_signed = 1'b0;
                alu_op     = cpu_pkg::ALU_OR;
            end
            `OPC_LHI: begin
                reg_write = 1'b1;
                alu_op    = cpu_pkg::ALU_LHI;
            end
            `OPC_LWD: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                uses_rs   = 1'b1;
            end
            `OPC_SWD: begin
                mem_write = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;  // store data
            end
            `OPC_BNE, `OPC_BEQ: begin
                is_branch    = 1'b1;
                branch_on_eq = (opcode == `OPC_BEQ);
                alu_src_imm  = 1'b0;
                alu_op       = cpu_pkg::ALU_SUB;
                uses_rs      = 1'b1;
                uses_rt      = 1'b1;
            end
            `OPC_JMP: is_jump = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::reg_idx_t raddr1,
    input  cpu_pkg::reg_idx_t raddr2,
    input  cpu_pkg::reg_idx_t waddr,
    input  cpu_pkg::word_t    wdata,
    input  logic              we,
    output cpu_pkg::word_t    rdata1,
    output cpu_pkg::word_t    rdata2
);
    cpu_pkg::word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through, so an instruction in writeback needs no stall
    assign rdata1 = (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t   result,
    output logic             equal
);

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: result = a + b;
            cpu_pkg::ALU_SUB: result = a - b;
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_OR:  result = a | b;
            cpu_pkg::ALU_LHI: result = {b[7:0], 8'h00};
            default:          result = '0;
        endcase
    end

    // branch condition, rs against rt
    assign equal = (a == b);

endmodule

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  cpu_pkg::reg_idx_t rs,
    input  cpu_pkg::reg_idx_t rt,
    input  logic              uses_rs,
    input  logic              uses_rt,
    input  cpu_pkg::reg_idx_t ex_dest,
    input  logic              ex_writes,
    input  cpu_pkg::reg_idx_t mem_dest,
    input  logic              mem_writes,
    output logic              stall
);
    logic rs_hit;
    logic rt_hit;

    // no forwarding, so any pending producer blocks decode
    assign rs_hit = uses_rs &&
                    ((ex_writes && ex_dest == rs) || (mem_writes && mem_dest == rs));
    assign rt_hit = uses_rt &&
                    ((ex_writes && ex_dest == rt) || (mem_writes && mem_dest == rt));

    assign stall = rs_hit || rt_hit;

endmodule

`default_nettype wire

// ==== hdl/pipeline_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module pipeline_datapath (
    input  logic           clk,
    input  logic           rst,
    output logic           read_m1,
    output cpu_pkg::word_t address1,
    input  cpu_pkg::word_t data1,
    output logic           read_m2,
    output logic           write_m2,
    output cpu_pkg::word_t address2,
    output cpu_pkg::word_t write_data2,
    input  cpu_pkg::word_t read_data2,
    output cpu_pkg::word_t output_port,
    output logic           output_valid,
    output cpu_pkg::word_t num_inst,
    output logic           is_halted
);
    cpu_pkg::word_t pc;

    // fetch/decode
    logic           fd_valid;
    cpu_pkg::word_t fd_pc;
    cpu_pkg::word_t fd_instr;

    // decode
    cpu_pkg::reg_idx_t id_rs;
    cpu_pkg::reg_idx_t id_rt;
    cpu_pkg::reg_idx_t id_dest;
    logic              id_reg_write;
    logic              id_alu_src_imm;
    logic              id_imm_signed;
    cpu_pkg::alu_op_t  id_alu_op;
    logic              id_mem_read;
    logic              id_mem_write;
    logic              id_is_branch;
    logic              id_branch_on_eq;
    logic              id_is_jump;
    logic              id_is_wwd;
    logic              id_is_halt;
    logic              id_uses_rs;
    logic              id_uses_rt;
    cpu_pkg::word_t    id_rdata1;
    cpu_pkg::word_t    id_rdata2;
    cpu_pkg::word_t    id_imm;
    logic              stall;
    logic              jump_taken;
    cpu_pkg::word_t    jump_target;

    // decode/execute
    logic              de_valid;
    cpu_pkg::word_t    de_pc;
    cpu_pkg::word_t    de_rdata1;
    cpu_pkg::word_t    de_rdata2;
    cpu_pkg::word_t    de_imm;
    cpu_pkg::reg_idx_t de_dest;
    logic              de_reg_write;
    logic              de_alu_src_imm;
    cpu_pkg::alu_op_t  de_alu_op;
    logic              de_mem_read;
    logic              de_mem_write;
    logic              de_is_branch;
    logic              de_branch_on_eq;
    logic              de_is_wwd;
    logic              de_is_halt;

    // execute
    cpu_pkg::word_t alu_b;
    cpu_pkg::word_t alu_result;
    logic           alu_equal;
    cpu_pkg::word_t branch_target;
    logic           branch_taken;

    // execute/memory
    logic              em_valid;
    cpu_pkg::word_t    em_result;
    cpu_pkg::word_t    em_store_data;
    cpu_pkg::reg_idx_t em_dest;
    logic              em_reg_write;
    logic              em_mem_read;
    logic              em_mem_write;
    logic              em_is_wwd;
    logic              em_is_halt;

    // memory/writeback
    logic              mw_valid;
    cpu_pkg::word_t    mw_result;
    cpu_pkg::reg_idx_t mw_dest;
    logic              mw_reg_write;
    logic              mw_is_wwd;
    logic              mw_is_halt;
    logic              wb_we;

    control_unit u_ctrl (
        .instr        (fd_instr),
        .rs           (id_rs),
        .rt           (id_rt),
        .dest         (id_dest),
        .reg_write    (id_reg_write),
        .alu_src_imm  (id_alu_src_imm),
        .imm_signed   (id_imm_signed),
        .alu_op       (id_alu_op),
        .mem_read     (id_mem_read),
        .mem_write    (id_mem_write),
        .is_branch    (id_is_branch),
        .branch_on_eq (id_branch_on_eq),
        .is_jump      (id_is_jump),
        .is_wwd       (id_is_wwd),
        .is_halt      (id_is_halt),
        .uses_rs      (id_uses_rs),
        .uses_rt      (id_uses_rt)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (id_rs),
        .raddr2 (id_rt),
        .waddr  (mw_dest),
        .wdata  (mw_result),
        .we     (wb_we),
        .rdata1 (id_rdata1),
        .rdata2 (id_rdata2)
    );

    hazard_unit u_hazard (
        .rs         (id_rs),
        .rt         (id_rt),
        .uses_rs    (id_uses_rs && fd_valid),
        .uses_rt    (id_uses_rt && fd_valid),
        .ex_dest    (de_dest),
        .ex_writes  (de_valid && de_reg_write),
        .mem_dest   (em_dest),
        .mem_writes (em_valid && em_reg_write),
        .stall      (stall)
    );

    alu u_alu (
        .a      (de_rdata1),
        .b      (alu_b),
        .op     (de_alu_op),
        .result (alu_result),
        .equal  (alu_equal)
    );

    assign id_imm = id_imm_signed ? {{(`WORD_SIZE-8){fd_instr[7]}}, fd_instr[7:0]}
                                  : {{(`WORD_SIZE-8){1'b0}}, fd_instr[7:0]};
    assign jump_taken  = fd_valid && id_is_jump;
    assign jump_target = {fd_pc[15:12], fd_instr[11:0]};

    assign alu_b         = de_alu_src_imm ? de_imm : de_rdata2;
    assign branch_target = de_pc + 16'd1 + de_imm;
    assign branch_taken  = de_valid && de_is_branch && (alu_equal == de_branch_on_eq);

    // branch redirect wins over jump, both win over stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            fd_valid <= 1'b0;
        end else if (!is_halted) begin
            if (branch_taken) begin
                pc       <= branch_target;
                fd_valid <= 1'b0;
            end else if (jump_taken) begin
                pc       <= jump_target;
                fd_valid <= 1'b0;
            end else if (!stall) begin
                pc       <= pc + 16'd1;
                fd_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!is_halted && !stall) begin
            fd_pc    <= pc;
            fd_instr <= data1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            de_valid <= 1'b0;
            em_valid <= 1'b0;
            mw_valid <= 1'b0;
        end else if (!is_halted) begin
            de_valid <= fd_valid && !stall && !branch_taken;  // bubble or flush
            em_valid <= de_valid;
            mw_valid <= em_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!is_halted) begin
            de_pc           <= fd_pc;
            de_rdata1       <= id_rdata1;
            de_rdata2       <= id_rdata2;
            de_imm          <= id_imm;
            de_dest         <= id_dest;
            de_reg_write    <= id_reg_write;
            de_alu_src_imm  <= id_alu_src_imm;
            de_alu_op       <= id_alu_op;
            de_mem_read     <= id_mem_read;
            de_mem_write    <= id_mem_write;
            de_is_branch    <= id_is_branch;
            de_branch_on_eq <= id_branch_on_eq;
            de_is_wwd       <= id_is_wwd;
            de_is_halt      <= id_is_halt;

            em_result     <= de_is_wwd ? de_rdata1 : alu_result;  // wwd carries rs
            em_store_data <= de_rdata2;
            em_dest       <= de_dest;
            em_reg_write  <= de_reg_write;
            em_mem_read   <= de_mem_read;
            em_mem_write  <= de_mem_write;
            em_is_wwd     <= de_is_wwd;
            em_is_halt    <= de_is_halt;

            mw_result    <= em_mem_read ? read_data2 : em_result;
            mw_dest      <= em_dest;
            mw_reg_write <= em_reg_write;
            mw_is_wwd    <= em_is_wwd;
            mw_is_halt   <= em_is_halt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            num_inst  <= '0;
            is_halted <= 1'b0;
        end else if (!is_halted && mw_valid) begin
            num_inst <= num_inst + 16'd1;
            if (mw_is_halt)
                is_halted <= 1'b1;
        end
    end

    assign read_m1  = !is_halted;
    assign address1 = pc;

    // a store behind a retiring HLT must not land
    assign read_m2     = em_valid && em_mem_read && !is_halted;
    assign write_m2    = em_valid && em_mem_write && !is_halted && !(mw_valid && mw_is_halt);
    assign address2    = em_result;
    assign write_data2 = em_store_data;

    assign wb_we        = mw_valid && mw_reg_write && !is_halted;
    assign output_valid = mw_valid && mw_is_wwd && !is_halted;
    assign output_port  = mw_result;

    assert property (@(posedge clk) disable iff (rst) !(read_m2 && write_m2))
        else $error("data port read and write in the same cycle");

    assert property (@(posedge clk) $fell(is_halted) |-> $past(rst))
        else $error("is_halted fell without reset");

endmodule

`default_nettype wire

// ==== tb/tb_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_memory (
    input  logic           clk,
    input  logic           read_m1,
    input  cpu_pkg::word_t address1,
    output cpu_pkg::word_t data1,
    input  logic           read_m2,
    input  logic           write_m2,
    input  cpu_pkg::word_t address2,
    input  cpu_pkg::word_t write_data2,
    output cpu_pkg::word_t read_data2
);
    localparam int DEPTH = 256;

    cpu_pkg::word_t imem [DEPTH];
    cpu_pkg::word_t dmem [DEPTH];

    // every index bit lands in the word
    function automatic cpu_pkg::word_t fill_value(input int idx);
        return {idx[7:0] ^ 8'ha5, idx[7:0]};
    endfunction

    // unused instruction slots hold HLT so a runaway fetch stops
    task automatic clear_images();
        for (int i = 0; i < DEPTH; i++) begin
            imem[i] = {`OPC_RTYPE, 6'd0, `FN_HLT};
            dmem[i] = fill_value(i);
        end
    endtask

    task automatic write_instr(input int addr, input cpu_pkg::word_t instr);
        imem[addr] = instr;
    endtask

    assign data1      = read_m1 ? imem[address1[7:0]] : '0;
    assign read_data2 = read_m2 ? dmem[address2[7:0]] : '0;

    always @(posedge clk) begin
        if (write_m2 === 1'b1)
            dmem[address2[7:0]] <= write_data2;
    end

endmodule

`default_nettype wire

// ==== tb/tb_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_datapath;
    localparam int CYCLE_LIMIT = 6 * 300;  // six tests of 300 cycles

    logic           clk;
    logic           rst;
    logic           read_m1;
    cpu_pkg::word_t address1;
    cpu_pkg::word_t data1;
    logic           read_m2;
    logic           write_m2;
    cpu_pkg::word_t address2;
    cpu_pkg::word_t write_data2;
    cpu_pkg::word_t read_data2;
    cpu_pkg::word_t output_port;
    logic           output_valid;
    cpu_pkg::word_t num_inst;
    logic           is_halted;

    int             value_errs = 0;
    int             other_errs = 0;
    int             cycles = 0;
    int             load_addr;
    int             seed_ret;
    string          test_name;
    cpu_pkg::word_t seen_q[$];
    cpu_pkg::word_t expect_q[$];
    cpu_pkg::word_t first_q[$];

    pipeline_datapath uut (
        .clk          (clk),
        .rst          (rst),
        .read_m1      (read_m1),
        .address1     (address1),
        .data1        (data1),
        .read_m2      (read_m2),
        .write_m2     (write_m2),
        .address2     (address2),
        .write_data2  (write_data2),
        .read_data2   (read_data2),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    tb_memory mem (
        .clk         (clk),
        .read_m1     (read_m1),
        .address1    (address1),
        .data1       (data1),
        .read_m2     (read_m2),
        .write_m2    (write_m2),
        .address2    (address2),
        .write_data2 (write_data2),
        .read_data2  (read_data2)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // output_valid lasts one full cycle, so the falling edge sees it once
    always @(negedge clk) begin
        if (!rst && output_valid === 1'b1)
            seen_q.push_back(output_port);
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: %s did not halt within %0d cycles", test_name, CYCLE_LIMIT);
            $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic cpu_pkg::word_t enc_r(input cpu_pkg::reg_idx_t rs,
                                             input cpu_pkg::reg_idx_t rt,
                                             input cpu_pkg::reg_idx_t rd,
                                             input cpu_pkg::func_t fn);
        return {`OPC_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic cpu_pkg::word_t enc_i(input cpu_pkg::opcode_t op,
                                             input cpu_pkg::reg_idx_t rs,
                                             input cpu_pkg::reg_idx_t rt,
                                             input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpu_pkg::word_t enc_j(input logic [11:0] target);
        return {`OPC_JMP, target};
    endfunction

    function automatic cpu_pkg::word_t wwd_instr(input cpu_pkg::reg_idx_t rs);
        return enc_r(rs, 2'd0, 2'd0, `FN_WWD);
    endfunction

    task automatic emit(input cpu_pkg::word_t instr);
        mem.write_instr(load_addr, instr);
        load_addr++;
    endtask

    task automatic load_const(input cpu_pkg::reg_idx_t r, input cpu_pkg::word_t v);
        emit(enc_i(`OPC_LHI, 2'd0, r, v[15:8]));
        emit(enc_i(`OPC_ORI, r, r, v[7:0]));
    endtask

    task automatic check_word(input cpu_pkg::word_t got, input cpu_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s %s got %h expected %h", $time, test_name, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_count(input cpu_pkg::word_t got, input cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s num_inst got %0d expected %0d", $time, test_name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s %s got %b expected %b", $time, test_name, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic start_reset(input string name);
        @(negedge clk);
        rst = 1'b1;
        test_name = name;
        seen_q.delete();
    endtask

    task automatic finish_reset();
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic begin_program();
        mem.clear_images();
        load_addr = 0;
        expect_q.delete();
    endtask

    task automatic run_to_halt();
        int n;
        while (is_halted !== 1'b1)
            @(negedge clk);
        n = seen_q.size();
        repeat (10) @(negedge clk);
        check_flag(is_halted, 1'b1, "is_halted after halt");
        check_flag(read_m1, 1'b0, "read_m1 after halt");
        if (seen_q.size() != n) begin
            $display("%s: output_valid was raised after the halt", test_name);
            other_errs++;
        end
    endtask

    task automatic compare_outputs(input cpu_pkg::word_t exp_count);
        if (seen_q.size() != expect_q.size()) begin
            $display("%s: %0d outputs seen but %0d expected", test_name,
                     seen_q.size(), expect_q.size());
            other_errs++;
        end
        for (int i = 0; i < seen_q.size() && i < expect_q.size(); i++)
            check_word(seen_q[i], expect_q[i], "output");
        check_count(num_inst, exp_count);
    endtask

    task automatic test_alu();
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        logic [7:0]     imm;
        logic [7:0]     hi;
        a   = 16'($urandom);
        b   = 16'($urandom);
        imm = 8'($urandom);
        hi  = 8'($urandom);
        start_reset("alu");
        begin_program();
        load_const(2'd0, a);
        load_const(2'd1, b);
        emit(enc_r(2'd0, 2'd1, 2'd2, `FN_ADD));
        emit(wwd_instr(2'd2));
        emit(enc_r(2'd0, 2'd1, 2'd2, `FN_SUB));
        emit(wwd_instr(2'd2));
        emit(enc_r(2'd0, 2'd1, 2'd2, `FN_AND));
        emit(wwd_instr(2'd2));
        emit(enc_r(2'd0, 2'd1, 2'd2, `FN_ORR));
        emit(wwd_instr(2'd2));
        emit(enc_i(`OPC_ADI, 2'd0, 2'd3, imm));
        emit(wwd_instr(2'd3));
        emit(enc_i(`OPC_LHI, 2'd0, 2'd3, hi));
        emit(wwd_instr(2'd3));
        emit(enc_r(2'd0, 2'd0, 2'd0, `FN_HLT));
        expect_q.push_back(a + b);
        expect_q.push_back(a - b);
        expect_q.push_back(a & b);
        expect_q.push_back(a | b);
        expect_q.push_back(a + {{8{imm[7]}}, imm});
        expect_q.push_back({hi, 8'h00});
        finish_reset();
        run_to_halt();
        compare_outputs(16'(load_addr));
    endtask

    task automatic test_memory();
        cpu_pkg::word_t v;
        v = 16'($urandom);
        start_reset("memory");
        begin_program();
        load_const(2'd0, 16'h0040);  // base
        load_const(2'd1, v);
        emit(enc_i(`OPC_SWD, 2'd0, 2'd1, 8'd3));
        emit(enc_i(`OPC_LWD, 2'd0, 2'd2, 8'd3));
        emit(enc_r(2'd2, 2'd1, 2'd3, `FN_ADD));  // load-use
        emit(wwd_instr(2'd2));
        emit(wwd_instr(2'd3));
        emit(enc_i(`OPC_SWD, 2'd0, 2'd3, 8'hfe));  // negative offset
        emit(enc_i(`OPC_LWD, 2'd0, 2'd1, 8'hfe));
        emit(wwd_instr(2'd1));
        emit(enc_i(`OPC_LWD, 2'd0, 2'd2, 8'd8));  // untouched word
        emit(wwd_instr(2'd2));
        emit(enc_r(2'd0, 2'd0, 2'd0, `FN_HLT));
        expect_q.push_back(v);
        expect_q.push_back(v + v);
        expect_q.push_back(v + v);
        expect_q.push_back(mem.fill_value(8'h48));
        finish_reset();
        run_to_halt();
        compare_outputs(16'(load_addr));
        check_word(mem.dmem[8'h43], v, "stored word");
        check_word(mem.dmem[8'h3e], v + v, "stored sum");
    endtask

    task automatic test_raw_chain();
        cpu_pkg::word_t x;
        x = 16'($urandom);
        start_reset("raw chain");
        begin_program();
        load_const(2'd0, x);
        emit(enc_r(2'd0, 2'd0, 2'd0, `FN_ADD));
        emit(enc_r(2'd0, 2'd0, 2'd0, `FN_ADD));
        emit(enc_r(2'd0, 2'd0, 2'd1, `FN_ADD));
        emit(enc_r(2'd1, 2'd0, 2'd2, `FN_SUB));
        emit(enc_i(`OPC_ADI, 2'd2, 2'd2, 8'd5));
        emit(wwd_instr(2'd0));
        emit(wwd_instr(2'd1));
        emit(wwd_instr(2'd2));
        emit(enc_r(2'd0, 2'd0, 2'd0, `FN_HLT));
        expect_q.push_back(x * 4);
        expect_q.push_back(x * 8);
        expect_q.push_back(x * 4 + 5);
        finish_reset();
        run_to_halt();
        compare_outputs(16'(load_addr));
    endtask

    task automatic test_control_flow();
        start_reset("control flow");
        begin_program();
        emit(enc_i(`OPC_ADI, 2'd0, 2'd0, 8'h11));
        emit(enc_i(`OPC_ADI, 2'd1, 2'd1, 8'h11));
        emit(enc_i(`OPC_ADI, 2'd2, 2'd2, 8'h22));
        emit(enc_i(`OPC_ADI, 2'd3, 2'd3, 8'h33));
        emit(enc_i(`OPC_BEQ, 2'd0, 2'd1, 8'd2));  // 4: taken to 7
        emit(wwd_instr(2'd2));
        emit(wwd_instr(2'd3));
        emit(wwd_instr(2'd0));                     // 7
        emit(enc_i(`OPC_BNE, 2'd0, 2'd1, 8'd2));  // 8: not taken
        emit(wwd_instr(2'd2));
        emit(wwd_instr(2'd3));
        emit(enc_i(`OPC_BNE, 2'd0, 2'd2, 8'd1));  // 11: taken to 13
        emit(wwd_instr(2'd2));
        emit(enc_i(`OPC_BEQ, 2'd0, 2'd2, 8'd1));  // 13: not taken
        emit(wwd_instr(2'd3));
        emit(enc_j(12'd18));                       // 15
        emit(wwd_instr(2'd2));
        emit(wwd_instr(2'd3));
        emit(wwd_instr(2'd0));                     // 18
        emit(enc_r(2'd0, 2'd0, 2'd0, `FN_HLT));
        expect_q.push_back(16'h0011);
        expect_q.push_back(16'h0022);
        expect_q.push_back(16'h0033);
        expect_q.push_back(16'h0033);
        expect_q.push_back(16'h0011);
        finish_reset();
        run_to_halt();
        compare_outputs(16'd15);  // 0-4, 7-11, 13-15, 18, 19
    endtask

    task automatic test_retire_halt();
        start_reset("retire and halt");
        begin_program();
        emit(enc_i(`OPC_ADI, 2'd0, 2'd1, 8'd7));
        emit(enc_i(`OPC_ADI, 2'd1, 2'd2, 8'hfd));
        emit(wwd_instr(2'd2));
        emit(enc_j(12'd6));
        emit(wwd_instr(2'd1));
        emit(wwd_instr(2'd1));
        emit(enc_r(2'd0, 2'd0, 2'd0, `FN_HLT));      // 6
        emit(enc_i(`OPC_SWD, 2'd0, 2'd1, 8'h10));    // in memory stage as HLT retires
        emit(wwd_instr(2'd1));                        // never retires
        emit(enc_i(`OPC_ADI, 2'd1, 2'd1, 8'd1));
        expect_q.push_back(16'd4);
        finish_reset();
        run_to_halt();
        compare_outputs(16'd5);
        check_word(mem.dmem[8'h10], mem.fill_value(8'h10), "word past the halt");
    endtask

    task automatic test_reset();
        start_reset("reset");
        begin_program();
        emit(enc_i(`OPC_ADI, 2'd0, 2'd1, 8'h21));
        emit(wwd_instr(2'd1));
        emit(enc_i(`OPC_ADI, 2'd1, 2'd1, 8'h21));
        emit(wwd_instr(2'd1));
        emit(enc_i(`OPC_ADI, 2'd1, 2'd1, 8'h21));
        emit(wwd_instr(2'd1));
        emit(enc_r(2'd0, 2'd0, 2'd0, `FN_HLT));
        expect_q.push_back(16'h0021);
        expect_q.push_back(16'h0042);
        expect_q.push_back(16'h0063);
        finish_reset();
        while (seen_q.size() == 0)
            @(negedge clk);
        start_reset("reset");  // mid-run
        finish_reset();
        check_count(num_inst, 16'd0);
        run_to_halt();
        compare_outputs(16'd7);
        first_q = seen_q;
        start_reset("reset rerun");  // from the halted state
        finish_reset();
        check_count(num_inst, 16'd0);
        check_flag(is_halted, 1'b0, "is_halted after reset");
        run_to_halt();
        compare_outputs(16'd7);
        for (int i = 0; i < seen_q.size() && i < first_q.size(); i++)
            check_word(seen_q[i], first_q[i], "rerun output");
    endtask

    initial begin
        rst      = 1'b1;
        seed_ret = $urandom(32'h8e30);
        test_alu();
        test_memory();
        test_raw_chain();
        test_control_flow();
        test_retire_halt();
        test_reset();
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/hazard_unit.sv
hdl/pipeline_datapath.sv
tb/tb_memory.sv
tb/tb_datapath.sv
